// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = periph_subsystem_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module gpio_port (
	input  logic                    wb_clk_i,
	input  logic                    wb_rst_i,
	input  periph_pkg::periph_req_t req_i,
	output periph_pkg::periph_rsp_t rsp_o,
	input  logic [15:0]             gpio_in_i,
	output logic [15:0]             gpio_out_o,
	output logic [15:0]             gpio_oe_o
);

	logic [15:0] out_q;
	logic [15:0] oe_q;
	logic [15:0] in_meta_q;
	logic [15:0] in_sync_q;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			out_q <= '0;
			oe_q <= '0;
		end else if (req_i.we) begin
			// the two low byte lanes are writable one at a time
			for (int i = 0; i < 2; i++) begin
				if (req_i.byte_sel[i] && req_i.addr.fld.reg_idx == `GPIO_REG_OUT) begin
					out_q[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
				end
				if (req_i.byte_sel[i] && req_i.addr.fld.reg_idx == `GPIO_REG_OE) begin
					oe_q[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
				end
			end
		end
	end

	// two flop synchronizer for the pad inputs
	always_ff @(posedge wb_clk_i) begin
		in_meta_q <= gpio_in_i;
		in_sync_q <= in_meta_q;
	end

	always_comb begin
		rsp_o.busy = 1'b0;
		rsp_o.err = 1'b0;
		rsp_o.rdata = '0;
		if (req_i.oe) begin
			case (req_i.addr.fld.reg_idx)
				`GPIO_REG_OUT: rsp_o.rdata = {16'h0, out_q};
				`GPIO_REG_OE:  rsp_o.rdata = {16'h0, oe_q};
				`GPIO_REG_IN:  rsp_o.rdata = {16'h0, in_sync_q};
				default:       rsp_o.rdata = '0;
			endcase
		end
	end

	assign gpio_out_o = out_q;
	assign gpio_oe_o = oe_q;

endmodule

`default_nettype wire

// ==== source/periph_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module periph_bus_decoder (
	input  periph_pkg::periph_req_t periph_req_i,
	output periph_pkg::periph_rsp_t periph_rsp_o,
	output periph_pkg::periph_req_t gpio_req_o,
	input  periph_pkg::periph_rsp_t gpio_rsp_i,
	output periph_pkg::periph_req_t tmr_req_o,
	input  periph_pkg::periph_rsp_t tmr_rsp_i
);

	import periph_pkg::*;

	periph_addr_u dec_addr;
	logic         gpio_hit;
	logic         tmr_hit;

	assign dec_addr = periph_req_i.addr;
	assign gpio_hit = (dec_addr.fld.dev_sel == `DEV_GPIO);
	assign tmr_hit = (dec_addr.fld.dev_sel == `DEV_TIMER);

	// only the selected device sees its strobes
	always_comb begin
		gpio_req_o = periph_req_i;
		gpio_req_o.we = periph_req_i.we & gpio_hit;
		gpio_req_o.oe = periph_req_i.oe & gpio_hit;

		tmr_req_o = periph_req_i;
		tmr_req_o.we = periph_req_i.we & tmr_hit;
		tmr_req_o.oe = periph_req_i.oe & tmr_hit;
	end

	// ****************************************
	// response merge
	// ****************************************

	always_comb begin
		if (gpio_hit) begin
			periph_rsp_o = gpio_rsp_i;
		end else if (tmr_hit) begin
			periph_rsp_o = tmr_rsp_i;
		end else begin
			// nobody owns this address, so finish at once with an error
			periph_rsp_o.busy = 1'b0;
			periph_rsp_o.err = 1'b1;
			periph_rsp_o.rdata = '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/periph_defines.svh ====
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// peripheral bus widths
`define PERIPH_ADDR_W 24
`define PERIPH_DATA_W 32
`define PERIPH_SEL_W  4

// device numbers live in the top address byte
`define DEV_GPIO  8'd0
`define DEV_TIMER 8'd1

// gpio register indices
`define GPIO_REG_OUT 6'd0
`define GPIO_REG_OE  6'd1
`define GPIO_REG_IN  6'd2

// timer register indices
`define TMR_REG_CTRL   6'd0
`define TMR_REG_COUNT  6'd1
`define TMR_REG_CMP    6'd2
`define TMR_REG_STATUS 6'd3

`endif

// ==== source/periph_pkg.sv ====
`default_nettype none

`include "periph_defines.svh"

package periph_pkg;

	// field view of a peripheral address
	typedef struct packed {
		logic [7:0] dev_sel;
		logic [7:0] page;
		logic [5:0] reg_idx;
		logic [1:0] byte_ofs;
	} periph_addr_f_t;

	// the same address word, read either raw or as fields
	typedef union packed {
		logic [`PERIPH_ADDR_W-1:0] raw;
		periph_addr_f_t            fld;
	} periph_addr_u;

	// ****************************************
	// peripheral bus request and response
	// ****************************************

	typedef struct packed {
		logic                      we;
		logic                      oe;
		periph_addr_u              addr;
		logic [`PERIPH_SEL_W-1:0]  byte_sel;
		logic [`PERIPH_DATA_W-1:0] wdata;
	} periph_req_t;

	typedef struct packed {
		logic                      busy;
		logic                      err;
		logic [`PERIPH_DATA_W-1:0] rdata;
	} periph_rsp_t;

endpackage

`default_nettype wire

// ==== source/periph_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module periph_subsystem_top (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_cyc_i,
	input  logic                      wb_we_i,
	input  logic [`PERIPH_SEL_W-1:0]  wb_sel_i,
	input  logic [`PERIPH_DATA_W-1:0] wb_data_i,
	input  logic [`PERIPH_ADDR_W-1:0] wb_adr_i,
	output logic                      wb_ack_o,
	output logic                      wb_stall_o,
	output logic                      wb_error_o,
	output logic [`PERIPH_DATA_W-1:0] wb_data_o,
	input  logic [15:0]               gpio_in_i,
	output logic [15:0]               gpio_out_o,
	output logic [15:0]               gpio_oe_o,
	output logic                      timer_irq_o
);

	import periph_pkg::*;

	periph_req_t bus_req;
	periph_rsp_t bus_rsp;
	periph_req_t gpio_req;
	periph_rsp_t gpio_rsp;
	periph_req_t tmr_req;
	periph_rsp_t tmr_rsp;

	wb_periph_bus_interface u_bridge (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.wb_stb_i     (wb_stb_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_we_i      (wb_we_i),
		.wb_sel_i     (wb_sel_i),
		.wb_data_i    (wb_data_i),
		.wb_adr_i     (wb_adr_i),
		.wb_ack_o     (wb_ack_o),
		.wb_stall_o   (wb_stall_o),
		.wb_error_o   (wb_error_o),
		.wb_data_o    (wb_data_o),
		.periph_req_o (bus_req),
		.periph_rsp_i (bus_rsp)
	);

	periph_bus_decoder u_decoder (
		.periph_req_i (bus_req),
		.periph_rsp_o (bus_rsp),
		.gpio_req_o   (gpio_req),
		.gpio_rsp_i   (gpio_rsp),
		.tmr_req_o    (tmr_req),
		.tmr_rsp_i    (tmr_rsp)
	);

	gpio_port u_gpio (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.req_i      (gpio_req),
		.rsp_o      (gpio_rsp),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.gpio_oe_o  (gpio_oe_o)
	);

	timer_block u_timer (
		.wb_clk_i    (wb_clk_i),
		.wb_rst_i    (wb_rst_i),
		.req_i       (tmr_req),
		.rsp_o       (tmr_rsp),
		.timer_irq_o (timer_irq_o)
	);

endmodule

`default_nettype wire

// ==== source/timer_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module timer_block (
	input  logic                    wb_clk_i,
	input  logic                    wb_rst_i,
	input  periph_pkg::periph_req_t req_i,
	output periph_pkg::periph_rsp_t rsp_o,
	output logic                    timer_irq_o
);

	logic                      en_q;
	logic                      match_q;
	logic                      seen_q;
	logic [`PERIPH_DATA_W-1:0] count_q;
	logic [`PERIPH_DATA_W-1:0] cmp_q;
	logic [`PERIPH_DATA_W-1:0] snap_q;
	logic                      active;
	logic                      wr_fire;
	logic [5:0]                reg_idx;

	assign active = req_i.oe | req_i.we;
	assign reg_idx = req_i.addr.fld.reg_idx;

	// the first cycle of an access is spent taking the count snapshot
	assign wr_fire = req_i.we & seen_q;

	always_ff @(posedge wb_clk_i) begin
		if (active && !seen_q) begin
			snap_q <= count_q;
		end
		if (wr_fire && reg_idx == `TMR_REG_CMP) begin
			cmp_q <= req_i.wdata;
		end
	end

	// ****************************************
	// counter, control and match flag
	// ****************************************

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			seen_q <= 1'b0;
			en_q <= 1'b0;
			match_q <= 1'b0;
			count_q <= '0;
		end else begin
			seen_q <= active;
			if (wr_fire && reg_idx == `TMR_REG_COUNT) begin
				count_q <= req_i.wdata;
			end else if (en_q) begin
				count_q <= count_q + 1'b1;
			end
			if (wr_fire && reg_idx == `TMR_REG_CTRL) begin
				en_q <= req_i.wdata[0];
			end
			// a new match wins over a clear in the same cycle
			if (en_q && count_q == cmp_q) begin
				match_q <= 1'b1;
			end else if (wr_fire && reg_idx == `TMR_REG_STATUS && req_i.wdata[0]) begin
				match_q <= 1'b0;
			end
		end
	end

	always_comb begin
		rsp_o.busy = active & ~seen_q;
		rsp_o.err = 1'b0;
		rsp_o.rdata = '0;
		if (req_i.oe) begin
			case (reg_idx)
				`TMR_REG_CTRL:   rsp_o.rdata = {31'h0, en_q};
				`TMR_REG_COUNT:  rsp_o.rdata = snap_q;
				`TMR_REG_CMP:    rsp_o.rdata = cmp_q;
				`TMR_REG_STATUS: rsp_o.rdata = {31'h0, match_q};
				default:         rsp_o.rdata = '0;
			endcase
		end
	end

	assign timer_irq_o = match_q;

endmodule

`default_nettype wire

// ==== source/wb_periph_bus_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module wb_periph_bus_interface (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_cyc_i,
	input  logic                      wb_we_i,
	input  logic [`PERIPH_SEL_W-1:0]  wb_sel_i,
	input  logic [`PERIPH_DATA_W-1:0] wb_data_i,
	input  logic [`PERIPH_ADDR_W-1:0] wb_adr_i,
	output logic                      wb_ack_o,
	output logic                      wb_stall_o,
	output logic                      wb_error_o,
	output logic [`PERIPH_DATA_W-1:0] wb_data_o,
	output periph_pkg::periph_req_t   periph_req_o,
	input  periph_pkg::periph_rsp_t   periph_rsp_i
);

	import periph_pkg::*;

	localparam logic [1:0] ST_IDLE   = 2'h0;
	localparam logic [1:0] ST_WRITE  = 2'h1;
	localparam logic [1:0] ST_READ   = 2'h2;
	localparam logic [1:0] ST_FINISH = 2'h3;

	logic [1:0]                state_q;
	logic                      stall_q;
	logic                      ack_q;
	logic                      err_q;
	logic [`PERIPH_DATA_W-1:0] rdata_q;
	logic                      accept;

	periph_addr_u              cur_addr_q;
	logic [`PERIPH_SEL_W-1:0]  cur_sel_q;
	logic [`PERIPH_DATA_W-1:0] cur_wdata_q;

	// strobes are only looked at while idle, so stall holds off the master
	assign accept = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i;

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			cur_addr_q.raw <= wb_adr_i;
			cur_sel_q <= wb_sel_i;
			cur_wdata_q <= wb_data_i;
		end
	end

	// ****************************************
	// cycle state machine
	// ****************************************

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state_q <= ST_IDLE;
			stall_q <= 1'b0;
			ack_q <= 1'b0;
			err_q <= 1'b0;
			rdata_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						state_q <= wb_we_i ? ST_WRITE : ST_READ;
						stall_q <= 1'b1;
					end
				end
				ST_WRITE, ST_READ: begin
					// wait here for as long as the peripheral reports busy
					if (!periph_rsp_i.busy) begin
						state_q <= ST_FINISH;
						ack_q <= !periph_rsp_i.err;
						err_q <= periph_rsp_i.err;
						if (state_q == ST_READ) begin
							rdata_q <= periph_rsp_i.rdata;
						end
					end
				end
				default: begin
					state_q <= ST_IDLE;
					stall_q <= 1'b0;
					ack_q <= 1'b0;
					err_q <= 1'b0;
					rdata_q <= '0;
				end
			endcase
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_error_o = err_q;
	assign wb_stall_o = stall_q;
	assign wb_data_o = rdata_q;

	always_comb begin
		periph_req_o.we = (state_q == ST_WRITE);
		periph_req_o.oe = (state_q == ST_READ);
		periph_req_o.addr = (state_q != ST_IDLE) ? cur_addr_q : '0;
		periph_req_o.byte_sel = (state_q != ST_IDLE) ? cur_sel_q : '0;
		periph_req_o.wdata = (state_q == ST_WRITE) ? cur_wdata_q : '0;
	end

endmodule

`default_nettype wire

// ==== tests/periph_subsystem_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_chk (
	input logic        wb_clk_i,
	input logic        wb_rst_i,
	input logic        cyc_i,
	input logic        stb_i,
	input logic        stall_i,
	input logic        ack_i,
	input logic        err_i,
	input logic        busy_i,
	input logic        req_we_i,
	input logic        req_oe_i,
	input logic [15:0] gpio_out_i,
	input logic [15:0] gpio_oe_i,
	input logic        irq_i
);

	int         fail_cnt = 0;
	logic       accept;
	logic       ended;
	logic [2:0] wait_cnt;
	logic       busy_q;
	logic       long_busy;

	assign accept = cyc_i && stb_i && !stall_i;
	assign ended = ack_i || err_i;

	// cycles since the bridge took the strobe, and whether busy lasted more than one cycle
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			wait_cnt <= '0;
			busy_q <= 1'b0;
			long_busy <= 1'b0;
		end else begin
			busy_q <= busy_i;
			if (accept) begin
				wait_cnt <= 3'd1;
				long_busy <= 1'b0;
			end else if (ended) begin
				wait_cnt <= '0;
			end else if (wait_cnt != 3'd0 && wait_cnt != 3'd7) begin
				wait_cnt <= wait_cnt + 3'd1;
			end
			if (busy_i && busy_q) begin
				long_busy <= 1'b1;
			end
		end
	end

	// ****************************************
	// response handshake
	// ****************************************

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) ack_i |=> !ack_i)
		else begin
			fail_cnt++;
			$error("wb_ack_o stayed high for more than one cycle");
		end

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) err_i |=> !err_i)
		else begin
			fail_cnt++;
			$error("wb_error_o stayed high for more than one cycle");
		end

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(ack_i && err_i))
		else begin
			fail_cnt++;
			$error("wb_ack_o and wb_error_o high together");
		end

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) (stall_i && !ended) |=> stall_i)
		else begin
			fail_cnt++;
			$error("wb_stall_o dropped before the cycle ended");
		end

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
			(ended && !long_busy) |-> (wait_cnt == 3'd2 || wait_cnt == 3'd3))
		else begin
			fail_cnt++;
			$error("cycle ended outside 2 to 3 cycles after acceptance");
		end

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
			(wait_cnt != 3'd0 && !long_busy) |-> (wait_cnt <= 3'd3))
		else begin
			fail_cnt++;
			$error("no ack or error within 3 cycles of acceptance");
		end

	assert property (@(posedge wb_clk_i) wb_rst_i |=> (!stall_i && !ack_i && !err_i
			&& !req_we_i && !req_oe_i && gpio_out_i == '0 && gpio_oe_i == '0 && !irq_i))
		else begin
			fail_cnt++;
			$error("control outputs not low after reset");
		end

endmodule

bind periph_subsystem_top periph_subsystem_chk chk0 (
	.wb_clk_i   (wb_clk_i),
	.wb_rst_i   (wb_rst_i),
	.cyc_i      (wb_cyc_i),
	.stb_i      (wb_stb_i),
	.stall_i    (wb_stall_o),
	.ack_i      (wb_ack_o),
	.err_i      (wb_error_o),
	.busy_i     (bus_rsp.busy),
	.req_we_i   (bus_req.we),
	.req_oe_i   (bus_req.oe),
	.gpio_out_i (gpio_out_o),
	.gpio_oe_i  (gpio_oe_o),
	.irq_i      (timer_irq_o)
);

`default_nettype wire

// ==== tests/periph_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module periph_subsystem_tb;

	logic        clk;
	logic        rst;
	logic        cyc, stb, we, ack, stall, err, irq;
	logic [3:0]  sel;
	logic [23:0] adr;
	logic [31:0] dat_w, dat_r;
	logic [15:0] gpio_in, gpio_out, gpio_oe;

	logic [31:0] lfsr;
	int          test_errs, tests_run, tests_failed, total_errs, timeouts;
	logic [15:0] exp_out, exp_oe;

	tb_clock_gen clkgen0 (
		.clk_o (clk),
		.rst_o (rst)
	);

	periph_subsystem_top dut0 (
		.wb_clk_i    (clk),
		.wb_rst_i    (rst),
		.wb_stb_i    (stb),
		.wb_cyc_i    (cyc),
		.wb_we_i     (we),
		.wb_sel_i    (sel),
		.wb_data_i   (dat_w),
		.wb_adr_i    (adr),
		.wb_ack_o    (ack),
		.wb_stall_o  (stall),
		.wb_error_o  (err),
		.wb_data_o   (dat_r),
		.gpio_in_i   (gpio_in),
		.gpio_out_o  (gpio_out),
		.gpio_oe_o   (gpio_oe),
		.timer_irq_o (irq)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [23:0] reg_addr(input logic [7:0] dev, input logic [5:0] idx);
		return {dev, 8'h00, idx, 2'b00};
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("check failed at %0d ns: %s", $time, what);
			test_errs++;
		end
	endtask

	// ****************************************
	// wishbone single cycle
	// ****************************************

	task automatic bus_access(input logic wr, input logic [23:0] a, input logic [3:0] s,
			input logic [31:0] d, output logic [31:0] rd, output logic got_ack,
			output logic got_err, output int cycles);
		int n;
		rd = '0;
		got_ack = 1'b0;
		got_err = 1'b0;
		cycles = 0;
		n = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		sel <= s;
		dat_w <= d;
		@(negedge clk);
		while (stall && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (stall) begin
			$display("bus access to %h was never accepted", a);
			test_errs++;
			timeouts++;
		end else begin
			// the bridge accepts at this edge and latches the write data with it
			@(posedge clk);
			stb <= 1'b0;
			dat_w <= ~d;
			do begin
				@(negedge clk);
				cycles++;
				expect_eq("wb_stall_o", 32'(stall), 32'd1);
				if (!(ack || err)) begin
					expect_eq("wb_data_o", dat_r, 32'd0);
				end
			end while (!(ack || err) && cycles < 20);
			if (ack || err) begin
				got_ack = ack;
				got_err = err;
				rd = dat_r;
			end else begin
				$display("bus access to %h never ended with ack or error", a);
				test_errs++;
				timeouts++;
			end
		end
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic bus_write(input logic [23:0] a, input logic [3:0] s, input logic [31:0] d);
		logic [31:0] rd;
		logic        ok, bad;
		int          cycles;
		bus_access(1'b1, a, s, d, rd, ok, bad, cycles);
		expect_eq("wb_ack_o", 32'(ok), 32'd1);
	endtask

	task automatic bus_read(input logic [23:0] a, output logic [31:0] rd);
		logic ok, bad;
		int   cycles;
		bus_access(1'b0, a, 4'hf, 32'd0, rd, ok, bad, cycles);
		expect_eq("wb_ack_o", 32'(ok), 32'd1);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, test_errs);
			tests_failed++;
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin
		logic [31:0] d, rd, c1, c2;
		logic        ok, bad;
		int          cycles, n;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = '0;
		adr = '0;
		dat_w = '0;
		gpio_in = '0;
		lfsr = 32'h4d38c995;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		total_errs = 0;
		timeouts = 0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (rst && n < 10);
		if (rst) begin
			$display("reset was never released");
			test_errs++;
			timeouts++;
		end

		exp_out = '0;
		exp_oe = '0;
		rand_bits(32, d);
		bus_write(reg_addr(`DEV_GPIO, `GPIO_REG_OUT), 4'hf, d);
		exp_out = d[15:0];
		rand_bits(32, d);
		bus_write(reg_addr(`DEV_GPIO, `GPIO_REG_OUT), 4'b0010, d);
		exp_out[15:8] = d[15:8];
		rand_bits(32, d);
		bus_write(reg_addr(`DEV_GPIO, `GPIO_REG_OE), 4'hf, d);
		exp_oe = d[15:0];
		rand_bits(32, d);
		bus_write(reg_addr(`DEV_GPIO, `GPIO_REG_OE), 4'b1101, d);
		exp_oe[7:0] = d[7:0];
		bus_read(reg_addr(`DEV_GPIO, `GPIO_REG_OUT), rd);
		expect_eq("wb_data_o gpio OUT", rd, {16'h0, exp_out});
		bus_read(reg_addr(`DEV_GPIO, `GPIO_REG_OE), rd);
		expect_eq("wb_data_o gpio OE", rd, {16'h0, exp_oe});
		@(negedge clk);
		expect_eq("gpio_out_o", 32'(gpio_out), 32'(exp_out));
		expect_eq("gpio_oe_o", 32'(gpio_oe), 32'(exp_oe));
		finish_test("gpio write and readback");

		rand_bits(16, d);
		@(posedge clk);
		gpio_in <= d[15:0];
		// two synchronizer edges plus one spare
		repeat (3) @(posedge clk);
		bus_read(reg_addr(`DEV_GPIO, `GPIO_REG_IN), rd);
		expect_eq("wb_data_o gpio IN", rd, {16'h0, d[15:0]});
		finish_test("gpio input");

		rand_bits(32, d);
		bus_access(1'b1, reg_addr(8'd5, `GPIO_REG_OUT), 4'hf, d, rd, ok, bad, cycles);
		expect_true(bad && !ok, "unmapped write did not end with wb_error_o alone");
		expect_eq("cycles to wb_error_o", cycles, 32'd2);
		bus_access(1'b0, reg_addr(8'd5, `GPIO_REG_OE), 4'hf, 32'd0, rd, ok, bad, cycles);
		expect_true(bad && !ok, "unmapped read did not end with wb_error_o alone");
		expect_eq("wb_data_o unmapped", rd, 32'd0);
		bus_read(reg_addr(`DEV_GPIO, `GPIO_REG_OUT), rd);
		expect_eq("wb_data_o gpio OUT", rd, {16'h0, exp_out});
		bus_read(reg_addr(`DEV_GPIO, `GPIO_REG_OE), rd);
		expect_eq("wb_data_o gpio OE", rd, {16'h0, exp_oe});
		finish_test("unmapped address");

		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_CTRL), 4'hf, 32'd1);
		bus_read(reg_addr(`DEV_TIMER, `TMR_REG_COUNT), c1);
		bus_read(reg_addr(`DEV_TIMER, `TMR_REG_COUNT), c2);
		expect_true(c2 > c1, "second COUNT read is not larger than the first");
		rand_bits(31, d);
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_COUNT), 4'hf, d);
		bus_read(reg_addr(`DEV_TIMER, `TMR_REG_COUNT), rd);
		expect_true(rd >= d && rd - d < 32, "COUNT read back is below or far past the load");
		finish_test("timer counting");

		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_CTRL), 4'hf, 32'd0);
		rand_bits(31, c1);
		c1 = c1 + 32'd64;
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_CMP), 4'hf, c1);
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_COUNT), 4'hf, c1 - 32'd40);
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_STATUS), 4'hf, 32'd1);
		@(negedge clk);
		expect_eq("timer_irq_o", 32'(irq), 32'd0);
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_CTRL), 4'hf, 32'd1);
		n = 0;
		@(negedge clk);
		while (!irq && n < 200) begin
			@(negedge clk);
			n++;
		end
		expect_true(irq, "timer_irq_o did not rise at the compare match");
		bus_read(reg_addr(`DEV_TIMER, `TMR_REG_STATUS), rd);
		expect_eq("wb_data_o timer STATUS", rd, 32'd1);
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_STATUS), 4'hf, 32'd1);
		@(negedge clk);
		expect_eq("timer_irq_o", 32'(irq), 32'd0);
		bus_write(reg_addr(`DEV_TIMER, `TMR_REG_CTRL), 4'hf, 32'd0);
		finish_test("compare interrupt");

		bus_access(1'b0, reg_addr(`DEV_GPIO, `GPIO_REG_OUT), 4'hf, 32'd0, rd, ok, bad, cycles);
		expect_eq("cycles to wb_ack_o gpio read", cycles, 32'd2);
		bus_access(1'b1, reg_addr(`DEV_GPIO, `GPIO_REG_OUT), 4'hf, {16'h0, exp_out},
			rd, ok, bad, cycles);
		expect_eq("cycles to wb_ack_o gpio write", cycles, 32'd2);
		bus_access(1'b0, reg_addr(`DEV_TIMER, `TMR_REG_CMP), 4'hf, 32'd0, rd, ok, bad, cycles);
		expect_eq("cycles to wb_ack_o timer read", cycles, 32'd3);
		bus_access(1'b1, reg_addr(`DEV_TIMER, `TMR_REG_CMP), 4'hf, c1, rd, ok, bad, cycles);
		expect_eq("cycles to wb_ack_o timer write", cycles, 32'd3);
		finish_test("cycle timing");

		$display("tests run %0d, failed %0d, errors %0d, timeouts %0d, assertion failures %0d",
			tests_run, tests_failed, total_errs, timeouts, dut0.chk0.fail_cnt);
		if (tests_failed == 0 && dut0.chk0.fail_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// reset covers the first two rising edges
	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/periph_pkg.sv
source/wb_periph_bus_interface.sv
source/periph_bus_decoder.sv
source/gpio_port.sv
source/timer_block.sv
source/periph_subsystem_top.sv
tests/tb_clock_gen.sv
tests/periph_subsystem_chk.sv
tests/periph_subsystem_tb.sv
